/* bench/decodeChecker.sv */
`timescale 1ns/100ps

module decodeChecker
    import frontPkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  rdy,
    input  logic                                  fetchEn,
    input  logic [InstWidth-1:0]                  fetchInst,
    input  logic [AddrWidth-1:0]                  fetchPc,
    input  logic                                  fetchPd,
    input  logic                                  queueFull,
    input  logic                                  commitEn,
    input  logic [TagWidth-1:0]                   commitTag,
    input  logic [NameWidth-1:0]                  commitRd,
    input  logic [DecodeWidth-1:0]                dispEn,
    input  opKind [DecodeWidth-1:0]               dispOp,
    input  logic [DecodeWidth-1:0][NameWidth-1:0] dispRd,
    input  logic [DecodeWidth-1:0][ImmWidth-1:0]  dispImm,
    input  logic [DecodeWidth-1:0][AddrWidth-1:0] dispPc,
    input  logic [DecodeWidth-1:0]                dispPd,
    input  logic [DecodeWidth-1:0][TagWidth-1:0]  dispTag,
    input  logic [DecodeWidth-1:0]                dispRs1Busy,
    input  logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs1Tag,
    input  logic [DecodeWidth-1:0]                dispRs2Busy,
    input  logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs2Tag,
    output int                                    mismatches,
    output int                                    otherErrors,
    output int                                    pending
);

    logic [InstWidth-1:0]   expInst [$];
    logic [AddrWidth-1:0]   expPc [$];
    logic                   expPd [$];
    logic [RegCount-1:0]    modelBusy;
    logic [TagWidth-1:0]    modelTag [RegCount];
    logic [TagWidth-1:0]    expTag;
    int                     freeModel;
    int                     queueModel;
    int                     decModel;
    logic [DecodeWidth-1:0] expEn;
    logic                   lastRdy;
    logic                   lastCommit;
    logic [TagWidth-1:0]    lastCommitTag;
    logic [NameWidth-1:0]   lastCommitRd;

    task automatic compare(input string name, input int lane, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s[%0d] at %0t: got %h expected %h", name, lane, $time, got, exp);
        end
    endtask

    // RV32I reference, fields a format does not use read as x0
    task automatic refDecode(input logic [31:0] inst, output opKind op,
                             output logic [4:0] rd, output logic [4:0] rs1,
                             output logic [4:0] rs2, output logic [31:0] imm);
        logic [6:0] opc;
        opc = inst[6:0];
        casez ({inst[30], inst[14:12], opc})  // {bit 30, funct3, opcode}
            11'b?_???_0110111: op = OpLui;
            11'b?_???_0010111: op = OpAuipc;
            11'b?_???_1101111: op = OpJal;
            11'b?_000_1100111: op = OpJalr;
            11'b?_000_1100011: op = OpBeq;
            11'b?_001_1100011: op = OpBne;
            11'b?_100_1100011: op = OpBlt;
            11'b?_101_1100011: op = OpBge;
            11'b?_110_1100011: op = OpBltu;
            11'b?_111_1100011: op = OpBgeu;
            11'b?_000_0000011: op = OpLb;
            11'b?_001_0000011: op = OpLh;
            11'b?_010_0000011: op = OpLw;
            11'b?_100_0000011: op = OpLbu;
            11'b?_101_0000011: op = OpLhu;
            11'b?_000_0100011: op = OpSb;
            11'b?_001_0100011: op = OpSh;
            11'b?_010_0100011: op = OpSw;
            11'b?_000_0010011: op = OpAddi;
            11'b0_001_0010011: op = OpSlli;
            11'b?_010_0010011: op = OpSlti;
            11'b?_011_0010011: op = OpSltiu;
            11'b?_100_0010011: op = OpXori;
            11'b0_101_0010011: op = OpSrli;
            11'b1_101_0010011: op = OpSrai;
            11'b?_110_0010011: op = OpOri;
            11'b?_111_0010011: op = OpAndi;
            11'b0_000_0110011: op = OpAdd;
            11'b1_000_0110011: op = OpSub;
            11'b0_001_0110011: op = OpSll;
            11'b0_010_0110011: op = OpSlt;
            11'b0_011_0110011: op = OpSltu;
            11'b0_100_0110011: op = OpXor;
            11'b0_101_0110011: op = OpSrl;
            11'b1_101_0110011: op = OpSra;
            11'b0_110_0110011: op = OpOr;
            11'b0_111_0110011: op = OpAnd;
            default:           op = OpNop;
        endcase
        case (opc)
            OpcLui, OpcAuipc: imm = {inst[31:12], 12'h000};
            OpcJal:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            OpcBranch: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            OpcStore:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OpcJalr, OpcLoad, OpcOpImm: imm = {{20{inst[31]}}, inst[31:20]};
            default:   imm = '0;  // R-type has no immediate
        endcase
        rd  = (opc inside {OpcBranch, OpcStore}) ? 5'd0 : inst[11:7];
        rs1 = (opc inside {OpcLui, OpcAuipc, OpcJal}) ? 5'd0 : inst[19:15];
        rs2 = (opc inside {OpcBranch, OpcStore, OpcOp}) ? inst[24:20] : 5'd0;
        if (op == OpNop) begin
            imm = '0;
            rd  = '0;
            rs1 = '0;
            rs2 = '0;
        end
    endtask

    task automatic expectSource(input string name, input int lane, input logic [4:0] src,
                                input logic gotBusy, input logic [TagWidth-1:0] gotTag);
        logic                expBusy;
        logic [TagWidth-1:0] expT;
        expBusy = src != '0 && modelBusy[src];
        expT    = expBusy ? modelTag[src] : '0;
        compare({name, "Busy"}, lane, 32'(gotBusy), 32'(expBusy));
        compare({name, "Tag"}, lane, 32'(gotTag), 32'(expT));
    endtask

    // dispEn seen here belongs to the edge before, together with lastCommit
    always @(posedge clk) begin
        opKind                op;
        logic [4:0]           rd;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [31:0]          imm;
        logic [InstWidth-1:0] inst;
        int                   count;
        int                   popped;
        logic                 pushed;
        if (rst) begin
            expInst.delete();
            expPc.delete();
            expPd.delete();
            modelBusy   = '0;
            expTag      = '0;
            freeModel   = RobSize;
            queueModel  = 0;
            decModel    = 0;
            expEn       = '0;
            lastRdy     = 1'b0;
            lastCommit  = 1'b0;
            mismatches  = 0;
            otherErrors = 0;
        end else begin
            if (lastCommit && modelTag[lastCommitRd] == lastCommitTag) begin
                modelBusy[lastCommitRd] = 1'b0;
            end
            count = 0;
            for (int i = 0; i < DecodeWidth; i++) begin
                count += int'(dispEn[i]);
                compare("dispEn", i, 32'(dispEn[i]), 32'(expEn[i]));
            end
            if (dispEn[1] && !dispEn[0]) begin
                otherErrors++;
                $display("lane 1 dispatched without lane 0 at %0t", $time);
            end
            if (count > 0 && !lastRdy) begin
                otherErrors++;
                $display("instructions dispatched on an edge with rdy low at %0t", $time);
            end
            if (count > freeModel) begin
                otherErrors++;
                $display("%0d dispatched with %0d free ROB entries at %0t",
                         count, freeModel, $time);
            end
            for (int i = 0; i < DecodeWidth; i++) begin
                if (dispEn[i] && expInst.size() == 0) begin
                    otherErrors++;
                    $display("lane %0d dispatched with nothing fetched at %0t", i, $time);
                end else if (dispEn[i]) begin
                    inst = expInst.pop_front();
                    refDecode(inst, op, rd, rs1, rs2, imm);
                    compare("dispPc", i, dispPc[i], expPc.pop_front());
                    compare("dispPd", i, 32'(dispPd[i]), 32'(expPd.pop_front()));
                    compare("dispOp", i, 32'(dispOp[i]), 32'(op));
                    compare("dispRd", i, 32'(dispRd[i]), 32'(rd));
                    compare("dispImm", i, dispImm[i], imm);
                    compare("dispTag", i, 32'(dispTag[i]), 32'(expTag));
                    expectSource("dispRs1", i, rs1, dispRs1Busy[i], dispRs1Tag[i]);
                    expectSource("dispRs2", i, rs2, dispRs2Busy[i], dispRs2Tag[i]);
                    if (rd != '0) begin
                        modelBusy[rd] = 1'b1;  // lane 1 then sees lane 0
                        modelTag[rd]  = expTag;
                    end
                    expTag = expTag + 1'b1;
                end
            end
            freeModel = freeModel - count + int'(lastCommit);
            if (queueFull !== (queueModel == QueueDepth)) begin
                mismatches++;
                $display("MISMATCH queueFull at %0t: got %h expected %h", $time, queueFull,
                         queueModel == QueueDepth);
            end
            // a decoded group moves on only if it fits the free ROB entries
            popped = 0;
            expEn  = '0;
            if (rdy && decModel <= freeModel) begin
                popped   = (queueModel < DecodeWidth) ? queueModel : DecodeWidth;
                expEn    = DecodeWidth'((1 << decModel) - 1);
                decModel = popped;
            end
            pushed = fetchEn && queueModel < QueueDepth;
            if (pushed) begin
                expInst.push_back(fetchInst);
                expPc.push_back(fetchPc);
                expPd.push_back(fetchPd);
            end
            queueModel    = queueModel + int'(pushed) - popped;
            lastRdy       = rdy;
            lastCommit    = commitEn;
            lastCommitTag = commitTag;
            lastCommitRd  = commitRd;
        end
        pending = expInst.size();
    end

endmodule

/* bench/decodeStageTb.sv */
`timescale 1ns/100ps

module decodeStageTb
    import frontPkg::*;
();

    localparam int NumFetch  = 600;
    localparam int CycleNs   = 10;
    localparam int TimeLimit = 20 * NumFetch * CycleNs;

    logic                                  clk = 1'b0;
    logic                                  rst;
    logic                                  rdy;
    logic                                  fetchEn;
    logic [InstWidth-1:0]                  fetchInst;
    logic [AddrWidth-1:0]                  fetchPc;
    logic                                  fetchPd;
    logic                                  commitEn;
    logic [TagWidth-1:0]                   commitTag;
    logic [NameWidth-1:0]                  commitRd;
    logic                                  queueFull;
    logic [DecodeWidth-1:0]                dispEn;
    opKind [DecodeWidth-1:0]               dispOp;
    logic [DecodeWidth-1:0][NameWidth-1:0] dispRd;
    logic [DecodeWidth-1:0][ImmWidth-1:0]  dispImm;
    logic [DecodeWidth-1:0][AddrWidth-1:0] dispPc;
    logic [DecodeWidth-1:0]                dispPd;
    logic [DecodeWidth-1:0][TagWidth-1:0]  dispTag;
    logic [DecodeWidth-1:0]                dispRs1Busy;
    logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs1Tag;
    logic [DecodeWidth-1:0]                dispRs2Busy;
    logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs2Tag;
    int                                    mismatches;
    int                                    otherErrors;
    int                                    pending;
    int                                    fetched;
    int                                    dispatched;
    logic [TagWidth-1:0]                   outTag [$];
    logic [NameWidth-1:0]                  outRd [$];

    decodeStage DUT (.*);

    decodeChecker watch (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] makeInst();
        logic [6:0]  majors [9];
        logic [31:0] word;
        majors = '{OpcLui, OpcAuipc, OpcJal, OpcJalr, OpcBranch,
                   OpcLoad, OpcStore, OpcOpImm, OpcOp};
        word = $urandom;
        if ($urandom % 10 == 0) begin
            return word;  // raw word, mostly not RV32I
        end
        word[6:0]   = majors[$urandom % 9];
        word[11:7]  = 5'($urandom % 8);  // few registers, many hazards
        word[19:15] = 5'($urandom % 8);
        word[24:20] = 5'($urandom % 8);
        case (word[6:0])
            OpcJalr:   word[14:12] = 3'b000;
            OpcBranch: word[14] = word[14] | word[13];
            OpcStore:  word[14:12] = 3'($urandom % 3);
            OpcLoad: begin
                if (word[14:12] inside {3'd3, 3'd6, 3'd7}) begin
                    word[14:12] = 3'b010;
                end
            end
            default: ;
        endcase
        if (word[6:0] == OpcOp || (word[6:0] == OpcOpImm && word[13:12] == 2'b01)) begin
            word[31:25] = 7'h00;
            if (word[14:12] inside {3'b000, 3'b101}) begin
                word[30] = 1'($urandom % 2);  // sub and sra/srai
            end
        end
        return word;
    endfunction

    initial begin
        #(TimeLimit);
        $display("timeout after %0d ns with %0d of %0d dispatched", TimeLimit,
                 dispatched, NumFetch);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(7));
        rst        = 1'b1;
        rdy        = 1'b0;
        fetchEn    = 1'b0;
        fetchInst  = '0;
        fetchPc    = '0;
        fetchPd    = 1'b0;
        commitEn   = 1'b0;
        commitTag  = '0;
        commitRd   = '0;
        fetched    = 0;
        dispatched = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (dispatched < NumFetch || outTag.size() != 0) begin
            @(negedge clk);
            for (int i = 0; i < DecodeWidth; i++) begin
                if (dispEn[i]) begin
                    outTag.push_back(dispTag[i]);  // oldest first
                    outRd.push_back(dispRd[i]);
                    dispatched++;
                end
            end
            rdy     = ($urandom % 100) >= 15;
            fetchEn = 1'b0;
            if (fetched < NumFetch && !queueFull) begin
                fetchEn   = 1'b1;
                fetchInst = makeInst();
                fetchPc   = 32'h1000 + 32'(4 * fetched);
                fetchPd   = 1'($urandom % 2);
                fetched++;
            end
            commitEn = 1'b0;
            if (outTag.size() != 0 && $urandom % 2 == 1) begin
                commitEn  = 1'b1;
                commitTag = outTag.pop_front();
                commitRd  = outRd.pop_front();
            end
        end
        @(negedge clk);
        commitEn = 1'b0;
        fetchEn  = 1'b0;
        repeat (3) @(negedge clk);
        $display("closing report: %0d mismatches, %0d other errors, %0d never dispatched",
                 mismatches, otherErrors, pending);
        if (mismatches == 0 && otherErrors == 0 && pending == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage
    import frontPkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  rdy,
    input  logic                                  fetchEn,
    input  logic [InstWidth-1:0]                  fetchInst,
    input  logic [AddrWidth-1:0]                  fetchPc,
    input  logic                                  fetchPd,
    input  logic                                  commitEn,
    input  logic [TagWidth-1:0]                   commitTag,
    input  logic [NameWidth-1:0]                  commitRd,
    output logic                                  queueFull,
    output logic [DecodeWidth-1:0]                dispEn,
    output opKind [DecodeWidth-1:0]               dispOp,
    output logic [DecodeWidth-1:0][NameWidth-1:0] dispRd,
    output logic [DecodeWidth-1:0][ImmWidth-1:0]  dispImm,
    output logic [DecodeWidth-1:0][AddrWidth-1:0] dispPc,
    output logic [DecodeWidth-1:0]                dispPd,
    output logic [DecodeWidth-1:0][TagWidth-1:0]  dispTag,
    output logic [DecodeWidth-1:0]                dispRs1Busy,
    output logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs1Tag,
    output logic [DecodeWidth-1:0]                dispRs2Busy,
    output logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs2Tag
);

    logic                                  stall;
    logic [DecodeWidth-1:0]                laneValid;
    logic [DecodeWidth-1:0][InstWidth-1:0] laneInst;
    logic [DecodeWidth-1:0][AddrWidth-1:0] lanePc;
    logic [DecodeWidth-1:0]                lanePd;
    logic [DecodeWidth-1:0]                decValid;
    opKind [DecodeWidth-1:0]               decOp;
    logic [DecodeWidth-1:0][NameWidth-1:0] decRd;
    logic [DecodeWidth-1:0][NameWidth-1:0] decRs1;
    logic [DecodeWidth-1:0][NameWidth-1:0] decRs2;
    logic [DecodeWidth-1:0][ImmWidth-1:0]  decImm;
    logic [DecodeWidth-1:0][AddrWidth-1:0] decPc;
    logic [DecodeWidth-1:0]                decPd;

    fetchQueue queue (.*);

    for (genvar i = 0; i < DecodeWidth; i++) begin : genLane
        instDecoder lane (
            .clk      (clk),
            .rst      (rst),
            .rdy      (rdy),
            .stall    (stall),
            .inValid  (laneValid[i]),
            .inInst   (laneInst[i]),
            .inPc     (lanePc[i]),
            .inPd     (lanePd[i]),
            .decValid (decValid[i]),
            .decOp    (decOp[i]),
            .decRd    (decRd[i]),
            .decRs1   (decRs1[i]),
            .decRs2   (decRs2[i]),
            .decImm   (decImm[i]),
            .decPc    (decPc[i]),
            .decPd    (decPd[i])
        );
    end

    dispatchUnit dispatch (.*);  // in-order issue, lane 0 oldest

endmodule

/* rtl/dispatchUnit.sv */
`timescale 1ns/100ps

module dispatchUnit
    import frontPkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  rdy,
    input  logic [DecodeWidth-1:0]                decValid,
    input  opKind [DecodeWidth-1:0]               decOp,
    input  logic [DecodeWidth-1:0][NameWidth-1:0] decRd,
    input  logic [DecodeWidth-1:0][NameWidth-1:0] decRs1,
    input  logic [DecodeWidth-1:0][NameWidth-1:0] decRs2,
    input  logic [DecodeWidth-1:0][ImmWidth-1:0]  decImm,
    input  logic [DecodeWidth-1:0][AddrWidth-1:0] decPc,
    input  logic [DecodeWidth-1:0]                decPd,
    input  logic                                  commitEn,
    input  logic [TagWidth-1:0]                   commitTag,
    input  logic [NameWidth-1:0]                  commitRd,
    output logic                                  stall,
    output logic [DecodeWidth-1:0]                dispEn,
    output opKind [DecodeWidth-1:0]               dispOp,
    output logic [DecodeWidth-1:0][NameWidth-1:0] dispRd,
    output logic [DecodeWidth-1:0][ImmWidth-1:0]  dispImm,
    output logic [DecodeWidth-1:0][AddrWidth-1:0] dispPc,
    output logic [DecodeWidth-1:0]                dispPd,
    output logic [DecodeWidth-1:0][TagWidth-1:0]  dispTag,
    output logic [DecodeWidth-1:0]                dispRs1Busy,
    output logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs1Tag,
    output logic [DecodeWidth-1:0]                dispRs2Busy,
    output logic [DecodeWidth-1:0][TagWidth-1:0]  dispRs2Tag
);

    logic [RegCount-1:0]                  busy;
    logic [TagWidth-1:0]                  tagTab [RegCount];
    logic [TagWidth-1:0]                  nextTag;
    logic [RobCntWidth-1:0]               freeCount;
    logic [RobCntWidth-1:0]               validCount;
    logic [RobCntWidth-1:0]               dispCnt;
    logic                                 go;
    logic [DecodeWidth-1:0]               rs1Busy;
    logic [DecodeWidth-1:0][TagWidth-1:0] rs1Tag;
    logic [DecodeWidth-1:0]               rs2Busy;
    logic [DecodeWidth-1:0][TagWidth-1:0] rs2Tag;

    // table lookup, then older lanes of the same group override it
    function automatic logic [TagWidth:0] renameSrc(input int lane,
                                                    input logic [NameWidth-1:0] name);
        logic                busyOut;
        logic [TagWidth-1:0] tagOut;
        busyOut = busy[name];
        tagOut  = tagTab[name];
        if (commitEn && commitRd == name && tagTab[name] == commitTag) begin
            busyOut = 1'b0;  // retiring this cycle
        end
        for (int j = 0; j < lane; j++) begin
            if (decValid[j] && decRd[j] == name) begin
                busyOut = 1'b1;
                tagOut  = nextTag + TagWidth'(j);
            end
        end
        if (name == '0 || !busyOut) begin
            busyOut = 1'b0;
            tagOut  = '0;
        end
        return {busyOut, tagOut};
    endfunction

    always_comb begin
        validCount = '0;
        for (int i = 0; i < DecodeWidth; i++) begin
            validCount = validCount + RobCntWidth'(decValid[i]);
            {rs1Busy[i], rs1Tag[i]} = renameSrc(i, decRs1[i]);
            {rs2Busy[i], rs2Tag[i]} = renameSrc(i, decRs2[i]);
        end
    end

    assign stall   = validCount > freeCount;  // whole group or nothing
    assign go      = rdy && !stall;
    assign dispCnt = go ? validCount : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= '0;
            nextTag   <= '0;
            freeCount <= RobCntWidth'(RobSize);
            dispEn    <= '0;
        end else begin
            if (commitEn && tagTab[commitRd] == commitTag) begin
                busy[commitRd] <= 1'b0;
            end
            for (int i = 0; i < DecodeWidth; i++) begin
                if (go && decValid[i] && decRd[i] != '0) begin
                    busy[decRd[i]] <= 1'b1;  // beats a same-cycle commit
                end
            end
            nextTag   <= nextTag + TagWidth'(dispCnt);
            freeCount <= freeCount - dispCnt + RobCntWidth'(commitEn);
            dispEn    <= go ? decValid : '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DecodeWidth; i++) begin
            if (go && decValid[i] && decRd[i] != '0) begin
                tagTab[decRd[i]] <= nextTag + TagWidth'(i);  // lane 1 wins on same rd
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            dispOp      <= decOp;
            dispRd      <= decRd;
            dispImm     <= decImm;
            dispPc      <= decPc;
            dispPd      <= decPd;
            dispRs1Busy <= rs1Busy;
            dispRs1Tag  <= rs1Tag;
            dispRs2Busy <= rs2Busy;
            dispRs2Tag  <= rs2Tag;
            for (int i = 0; i < DecodeWidth; i++) begin
                dispTag[i] <= nextTag + TagWidth'(i);
            end
        end
    end

endmodule

/* rtl/fetchQueue.sv */
`timescale 1ns/100ps

module fetchQueue
    import frontPkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  rdy,
    input  logic                                  stall,
    input  logic                                  fetchEn,
    input  logic [InstWidth-1:0]                  fetchInst,
    input  logic [AddrWidth-1:0]                  fetchPc,
    input  logic                                  fetchPd,
    output logic                                  queueFull,
    output logic [DecodeWidth-1:0]                laneValid,
    output logic [DecodeWidth-1:0][InstWidth-1:0] laneInst,
    output logic [DecodeWidth-1:0][AddrWidth-1:0] lanePc,
    output logic [DecodeWidth-1:0]                lanePd
);

    logic [InstWidth-1:0]     instMem [QueueDepth];
    logic [AddrWidth-1:0]     pcMem   [QueueDepth];
    logic                     pdMem   [QueueDepth];
    logic [QueuePtrWidth-1:0] rdPtr;
    logic [QueuePtrWidth-1:0] wrPtr;
    logic [QueueCntWidth-1:0] count;
    logic [QueueCntWidth-1:0] popCnt;
    logic                     push;

    assign queueFull = count == QueueCntWidth'(QueueDepth);
    assign push      = fetchEn && !queueFull;  // full strobes are lost

    // lane 0 always shows the oldest entry
    always_comb begin
        popCnt = '0;
        for (int i = 0; i < DecodeWidth; i++) begin
            laneValid[i] = count > QueueCntWidth'(i);
            laneInst[i]  = instMem[QueuePtrWidth'(rdPtr + i)];
            lanePc[i]    = pcMem[QueuePtrWidth'(rdPtr + i)];
            lanePd[i]    = pdMem[QueuePtrWidth'(rdPtr + i)];
            if (laneValid[i] && rdy && !stall) begin
                popCnt = popCnt + 1'b1;  // lanes take everything shown
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            instMem[wrPtr] <= fetchInst;
            pcMem[wrPtr]   <= fetchPc;
            pdMem[wrPtr]   <= fetchPd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            rdPtr <= rdPtr + QueuePtrWidth'(popCnt);  // wraps at depth
            count <= count + QueueCntWidth'(push) - popCnt;
        end
    end

endmodule

/* rtl/frontPkg.sv */
package frontPkg;

    localparam int DecodeWidth = 2;
    localparam int QueueDepth  = 8;
    localparam int RobSize     = 16;
    localparam int TagWidth    = 4;
    localparam int InstWidth   = 32;
    localparam int AddrWidth   = 32;
    localparam int ImmWidth    = 32;
    localparam int NameWidth   = 5;

    localparam int RegCount      = 2 ** NameWidth;
    localparam int QueuePtrWidth = $clog2(QueueDepth);
    localparam int QueueCntWidth = $clog2(QueueDepth + 1);
    localparam int RobCntWidth   = $clog2(RobSize + 1);

    // major opcodes of RV32I
    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcAuipc  = 7'b0010111;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcBranch = 7'b1100011;
    localparam logic [6:0] OpcLoad   = 7'b0000011;
    localparam logic [6:0] OpcStore  = 7'b0100011;
    localparam logic [6:0] OpcOpImm  = 7'b0010011;
    localparam logic [6:0] OpcOp     = 7'b0110011;

    typedef enum logic [5:0] {
        OpNop,  // also the reset value
        OpLui, OpAuipc, OpJal, OpJalr,
        OpBeq, OpBne, OpBlt, OpBge, OpBltu, OpBgeu,
        OpLb, OpLh, OpLw, OpLbu, OpLhu,
        OpSb, OpSh, OpSw,
        OpAddi, OpSlti, OpSltiu, OpXori, OpOri, OpAndi,
        OpSlli, OpSrli, OpSrai,
        OpAdd, OpSub, OpSll, OpSlt, OpSltu,
        OpXor, OpSrl, OpSra, OpOr, OpAnd
    } opKind;

endpackage

/* rtl/instDecoder.sv */
`timescale 1ns/100ps

module instDecoder
    import frontPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 stall,
    input  logic                 inValid,
    input  logic [InstWidth-1:0] inInst,
    input  logic [AddrWidth-1:0] inPc,
    input  logic                 inPd,
    output logic                 decValid,
    output opKind                decOp,
    output logic [NameWidth-1:0] decRd,
    output logic [NameWidth-1:0] decRs1,
    output logic [NameWidth-1:0] decRs2,
    output logic [ImmWidth-1:0]  decImm,
    output logic [AddrWidth-1:0] decPc,
    output logic                 decPd
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [3:0]          funct;
    opKind               opNext;
    logic [ImmWidth-1:0] immRaw;
    logic                hasRd;
    logic                hasRs1;
    logic                hasRs2;

    assign opcode = inInst[6:0];
    assign funct3 = inInst[14:12];
    assign funct  = {inInst[30], funct3};  // bit 30 splits add/sub, srl/sra

    always_comb begin
        case (opcode)
            OpcLui, OpcAuipc: immRaw = {inInst[31:12], 12'b0};
            OpcJal: immRaw = {{12{inInst[31]}}, inInst[19:12], inInst[20], inInst[30:21], 1'b0};
            OpcBranch: immRaw = {{20{inInst[31]}}, inInst[7], inInst[30:25], inInst[11:8], 1'b0};
            OpcJalr, OpcOpImm, OpcLoad: immRaw = {{21{inInst[31]}}, inInst[30:20]};
            OpcStore: immRaw = {{21{inInst[31]}}, inInst[30:25], inInst[11:7]};
            default: immRaw = '0;
        endcase
    end

    always_comb begin
        opNext = OpNop;
        case (opcode)
            OpcLui:   opNext = OpLui;
            OpcAuipc: opNext = OpAuipc;
            OpcJal:   opNext = OpJal;
            OpcJalr:  opNext = (funct3 == 3'b000) ? OpJalr : OpNop;
            OpcBranch: begin
                case (funct3)
                    3'b000:  opNext = OpBeq;
                    3'b001:  opNext = OpBne;
                    3'b100:  opNext = OpBlt;
                    3'b101:  opNext = OpBge;
                    3'b110:  opNext = OpBltu;
                    3'b111:  opNext = OpBgeu;
                    default: opNext = OpNop;
                endcase
            end
            OpcLoad: begin
                case (funct3)
                    3'b000:  opNext = OpLb;
                    3'b001:  opNext = OpLh;
                    3'b010:  opNext = OpLw;
                    3'b100:  opNext = OpLbu;
                    3'b101:  opNext = OpLhu;
                    default: opNext = OpNop;
                endcase
            end
            OpcStore: begin
                case (funct3)
                    3'b000:  opNext = OpSb;
                    3'b001:  opNext = OpSh;
                    3'b010:  opNext = OpSw;
                    default: opNext = OpNop;
                endcase
            end
            OpcOpImm: begin
                case (funct3)
                    3'b000:  opNext = OpAddi;
                    3'b001:  opNext = inInst[30] ? OpNop : OpSlli;
                    3'b010:  opNext = OpSlti;
                    3'b011:  opNext = OpSltiu;
                    3'b100:  opNext = OpXori;
                    3'b101:  opNext = inInst[30] ? OpSrai : OpSrli;
                    3'b110:  opNext = OpOri;
                    default: opNext = OpAndi;
                endcase
            end
            OpcOp: begin
                case (funct)
                    4'b0000: opNext = OpAdd;
                    4'b1000: opNext = OpSub;
                    4'b0001: opNext = OpSll;
                    4'b0010: opNext = OpSlt;
                    4'b0011: opNext = OpSltu;
                    4'b0100: opNext = OpXor;
                    4'b0101: opNext = OpSrl;
                    4'b1101: opNext = OpSra;
                    4'b0110: opNext = OpOr;
                    4'b0111: opNext = OpAnd;
                    default: opNext = OpNop;
                endcase
            end
            default: opNext = OpNop;
        endcase
    end

    // register fields that the format really uses, others read as x0
    always_comb begin
        hasRd  = 1'b0;
        hasRs1 = 1'b0;
        hasRs2 = 1'b0;
        if (opNext != OpNop) begin
            hasRd  = !(opcode inside {OpcBranch, OpcStore});
            hasRs1 = !(opcode inside {OpcLui, OpcAuipc, OpcJal});
            hasRs2 = opcode inside {OpcBranch, OpcStore, OpcOp};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (rdy && !stall) begin
            decValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && !stall) begin
            decOp  <= opNext;
            decRd  <= hasRd ? inInst[11:7] : '0;
            decRs1 <= hasRs1 ? inInst[19:15] : '0;
            decRs2 <= hasRs2 ? inInst[24:20] : '0;
            decImm <= (opNext == OpNop) ? '0 : immRaw;
            decPc  <= inPc;
            decPd  <= inPd;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build the decode stage testbench with Verilator, run it, look for the pass line
verilator --binary --timing -Wno-fatal -f verilog.f --top-module decodeStageTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
    && echo "run.sh: passed" \
    || { echo "run.sh: failed"; exit 1; }

/* verilog.f */
rtl/frontPkg.sv
rtl/fetchQueue.sv
rtl/instDecoder.sv
rtl/dispatchUnit.sv
rtl/decodeStage.sv
bench/decodeChecker.sv
bench/decodeStageTb.sv
